// ==== hw/lsu_pkg.sv ====
// shared widths and encodings for the load/store unit
// design exists at 32 bits only, no other width is supported
// size encoding 2'b11 is not named and decodes as a byte

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;           // byte address
  localparam int DATA_W = 32;           // bus word
  localparam int BE_W   = DATA_W / 8;   // one enable per byte lane
  localparam int BYTE_W = 8;
  localparam int HALF_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // access size from execute stage
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } data_type_e;

  // bus request fsm
  typedef enum logic [1:0] {
    ST_IDLE,                  // nothing outstanding
    ST_WAIT_RVALID,           // granted, waiting on response
    ST_WAIT_RVALID_EX_STALL,  // granted while ex stalled
    ST_IDLE_EX_STALL          // response in, ex still stalled
  } lsu_state_e;

endpackage

// ==== hw/lsu_store_align.sv ====
// store side byte enables and write data lane rotation
// aligned accesses only, misaligned offsets give undefined lanes
// purely combinational from the execute stage inputs

`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::data_type_e             data_type_ex_i,   // access size
  input  logic [1:0]                      addr_off_i,       // byte offset in word
  input  logic [lsu_pkg::DATA_W-1:0]      data_wdata_ex_i,  // unaligned store data
  output logic [lsu_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]      data_wdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      lsu_pkg::SIZE_WORD:
      begin
        data_be_o = '1;                                  // all four lanes
      end
      lsu_pkg::SIZE_HALF:
      begin
        data_be_o = addr_off_i[1] ? 4'b1100 : 4'b0011;  // upper or lower pair
      end
      default:
      begin
        // byte, also the unnamed 2'b11 code
        data_be_o = lsu_pkg::BE_W'(1) << addr_off_i;
      end
    endcase
  end

  // rotate left so low bytes of the data land on the enabled lanes
  always_comb
  begin
    case (addr_off_i)
      2'b00:   data_wdata_o = data_wdata_ex_i;
      2'b01:   data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10:   data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0],  data_wdata_ex_i[31:8]};
    endcase
  end

endmodule

// ==== hw/lsu_load_align.sv ====
// load side extraction, sign extension and held result
// access info is captured on the grant and used in the response cycle
// halfword offsets must have bit 0 clear, words must be word aligned

`timescale 1ns/1ps

module lsu_load_align (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            grant_accept_i,      // req and gnt both high
  input  lsu_pkg::data_type_e             data_type_ex_i,
  input  logic [1:0]                      addr_off_i,
  input  logic                            data_sign_ext_ex_i,
  input  logic                            data_we_ex_i,
  input  logic                            data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]      data_rdata_i,
  output logic [lsu_pkg::DATA_W-1:0]      data_rdata_ex_o
);

  lsu_pkg::data_type_e                type_q;      // size of the outstanding access
  logic [1:0]                         off_q;       // its byte offset
  logic                               sign_q;
  logic                               we_q;        // outstanding access is a store

  logic [lsu_pkg::DATA_W-1:0]         rdata_half;  // word shifted down to the halfword
  logic [lsu_pkg::DATA_W-1:0]         rdata_byte;  // word shifted down to the byte
  logic [lsu_pkg::DATA_W-1:0]         rdata_ext;
  logic [lsu_pkg::DATA_W-1:0]         rdata_q;     // result held for the pipeline

  ////////////////////////////////////////////////////////////////////////////
  // access info, one request outstanding at most
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q <= lsu_pkg::SIZE_WORD;
      off_q  <= 2'b00;
      sign_q <= 1'b0;
      we_q   <= 1'b0;
    end
    else if (grant_accept_i)
    begin
      type_q <= data_type_ex_i;
      off_q  <= addr_off_i;
      sign_q <= data_sign_ext_ex_i;
      we_q   <= data_we_ex_i;
    end
  end

  // halfword picks on offset bit 1 only
  assign rdata_half = data_rdata_i >> {off_q[1], 4'b0000};
  assign rdata_byte = data_rdata_i >> {off_q, 3'b000};

  always_comb
  begin
    case (type_q)
      lsu_pkg::SIZE_WORD:
      begin
        rdata_ext = data_rdata_i;
      end
      lsu_pkg::SIZE_HALF:
      begin
        rdata_ext = {{(lsu_pkg::DATA_W - lsu_pkg::HALF_W){sign_q & rdata_half[15]}},
                     rdata_half[lsu_pkg::HALF_W-1:0]};
      end
      default:
      begin
        rdata_ext = {{(lsu_pkg::DATA_W - lsu_pkg::BYTE_W){sign_q & rdata_byte[7]}},
                     rdata_byte[lsu_pkg::BYTE_W-1:0]};
      end
    endcase
  end

  // keep the last load result, store responses leave it alone
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
      rdata_q <= rdata_ext;
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // bypass in rvalid cycle

endmodule

// ==== hw/lsu_ctrl_fsm.sv ====
// bus request control for a req/gnt/rvalid data bus
// one request outstanding, response at least one cycle after grant
// data_err_i is only meaningful together with data_gnt_i

`timescale 1ns/1ps

module lsu_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,    // ex stage wants an access
  input  logic data_we_ex_i,     // store when high
  input  logic ex_valid_i,       // ex stage advances this cycle
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  output logic data_req_o,
  output logic grant_accept_o,   // request taken by the bus
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o
);

  lsu_pkg::lsu_state_e state_q;
  lsu_pkg::lsu_state_e state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::ST_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and handshake outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      lsu_pkg::ST_IDLE:
      begin
        if (data_req_ex_i)
        begin
          data_req_o     = 1'b1;
          lsu_ready_ex_o = data_gnt_i;   // ex holds until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? lsu_pkg::ST_WAIT_RVALID
                                 : lsu_pkg::ST_WAIT_RVALID_EX_STALL;
        end
      end

      lsu_pkg::ST_WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;  // wb waits on the response
        if (data_rvalid_i)
        begin
          state_d = lsu_pkg::ST_IDLE;
          // chain the next access into the response cycle
          if (data_req_ex_i)
          begin
            data_req_o     = 1'b1;
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? lsu_pkg::ST_WAIT_RVALID
                                   : lsu_pkg::ST_WAIT_RVALID_EX_STALL;
          end
        end
      end

      lsu_pkg::ST_WAIT_RVALID_EX_STALL:
      begin
        // no new request here, the ex stage still holds the old access
        if (data_rvalid_i)
          state_d = ex_valid_i ? lsu_pkg::ST_IDLE : lsu_pkg::ST_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = lsu_pkg::ST_WAIT_RVALID;   // stall gone, plain wait
      end

      lsu_pkg::ST_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = lsu_pkg::ST_IDLE;
      end

      default:
      begin
        state_d = lsu_pkg::ST_IDLE;
      end
    endcase
  end

  assign grant_accept_o = data_req_o & data_gnt_i;

  // bus errors come with the grant
  assign load_err_o  = data_gnt_i & data_err_i & ~data_we_ex_i;
  assign store_err_o = data_gnt_i & data_err_i &  data_we_ex_i;

  assign busy_o = (state_q != lsu_pkg::ST_IDLE) | data_req_o;

endmodule

// ==== hw/lsu_top.sv ====
// load/store unit between the execute stage and a req/gnt/rvalid bus
// address arrives finished from ex, aligned accesses only
// words need addr[1:0] zero, halfwords addr[0] zero

`timescale 1ns/1ps

module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n,

  // execute stage side
  input  logic                        data_req_ex_i,
  input  logic                        data_we_ex_i,
  input  lsu_pkg::data_type_e         data_type_ex_i,
  input  logic                        data_sign_ext_ex_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  data_addr_ex_i,
  input  logic [lsu_pkg::DATA_W-1:0]  data_wdata_ex_i,
  input  logic                        ex_valid_i,
  output logic [lsu_pkg::DATA_W-1:0]  data_rdata_ex_o,
  output logic                        lsu_ready_ex_o,
  output logic                        lsu_ready_wb_o,
  output logic                        load_err_o,
  output logic                        store_err_o,
  output logic                        busy_o,

  // data bus
  output logic                        data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]  data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]  data_wdata_o,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  input  logic                        data_err_i,
  input  logic [lsu_pkg::DATA_W-1:0]  data_rdata_i
);

  logic grant_accept;   // fsm to load side capture

  assign data_addr_o = data_addr_ex_i;
  assign data_we_o   = data_we_ex_i;

  lsu_store_align u_store_align (
    .data_type_ex_i  (data_type_ex_i),
    .addr_off_i      (data_addr_ex_i[1:0]),
    .data_wdata_ex_i (data_wdata_ex_i),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk                (clk),
    .rst_n              (rst_n),
    .grant_accept_i     (grant_accept),
    .data_type_ex_i     (data_type_ex_i),
    .addr_off_i         (data_addr_ex_i[1:0]),
    .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .data_we_ex_i       (data_we_ex_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_rdata_i       (data_rdata_i),
    .data_rdata_ex_o    (data_rdata_ex_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_we_ex_i   (data_we_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .grant_accept_o (grant_accept),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o),
    .busy_o         (busy_o)
  );

endmodule

// ==== tb/lsu_assert.sv ====
// bus protocol checks, bound into the lsu top level
// fsm state is picked up from the ctrl fsm instance

`timescale 1ns/1ps

module lsu_assert (
  input logic                       clk,
  input logic                       rst_n,
  input lsu_pkg::lsu_state_e        state_i,
  input logic                       data_req_i,
  input logic [lsu_pkg::ADDR_W-1:0] data_addr_i,
  input logic                       data_gnt_i,
  input logic                       data_rvalid_i,
  input logic                       data_err_i
);

  // response only while something is outstanding
  no_rvalid_in_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == lsu_pkg::ST_IDLE) |-> !data_rvalid_i)
    else $error("rvalid seen while fsm idle");

  err_needs_gnt : assert property (@(posedge clk) disable iff (!rst_n)
    data_err_i |-> data_gnt_i)
    else $error("bus error without grant");

  addr_known : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !$isunknown(data_addr_i))
    else $error("unknown address on request");

endmodule

bind lsu_top lsu_assert u_lsu_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_i       (u_ctrl_fsm.state_q),
  .data_req_i    (data_req_o),
  .data_addr_i   (data_addr_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_err_i    (data_err_i)
);

// ==== tb/tb_lsu_top.sv ====
// directed tests for the lsu against a 16 word memory model
// grant delay is random per request and rvalid follows one cycle after the grant
// addresses at and above 0x40 answer with a bus error

`timescale 1ns/1ps

module tb_lsu_top;

  localparam logic [31:0] FAULT_BASE = 32'h40;
  localparam int MAX_CYCLES = 2 * (25 * 8 + 30);   // 25 accesses of 8 cycles plus stall slack

  logic clk = 1'b0;
  logic rst_n;
  logic data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i, ex_valid_i;
  lsu_pkg::data_type_e data_type_ex_i;
  logic [31:0] data_addr_ex_i, data_wdata_ex_i, data_rdata_ex_o;
  logic lsu_ready_ex_o, lsu_ready_wb_o, load_err_o, store_err_o, busy_o;
  logic data_req_o, data_we_o;
  logic data_gnt_i = 1'b0;      // bus inputs quiet until the model resets
  logic data_rvalid_i = 1'b0;
  logic data_err_i = 1'b0;
  logic [31:0] data_rdata_i = '0;
  logic [31:0] data_addr_o, data_wdata_o;
  logic [3:0] data_be_o;

  logic [31:0] mem [16];       // memory model contents
  logic [31:0] ref_mem [16];   // expected contents
  logic [31:0] seed = 32'h57b3_d59b;
  logic        pending;
  logic [1:0]  wait_cnt;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;

  always #2 clk = ~clk;

  lsu_top UUT (.*);

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  initial
  begin
    for (int i = 0; i < 16; i++)
    begin
      mem[i]     = (i + 1) * 32'h9e37_79b9;   // mixes the word index into every byte
      ref_mem[i] = (i + 1) * 32'h9e37_79b9;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_gnt_i    <= 1'b0;
      data_err_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_rdata_i  <= '0;
      pending       <= 1'b0;
      wait_cnt      <= '0;
    end
    else
    begin
      data_rvalid_i <= 1'b0;
      if (data_req_o && data_gnt_i)
      begin
        data_gnt_i    <= 1'b0;    // accepted so the answer comes next cycle
        data_err_i    <= 1'b0;
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= mem[data_addr_o[5:2]];
        if (data_we_o && data_addr_o < FAULT_BASE)
          for (int k = 0; k < 4; k++)
            if (data_be_o[k])
              mem[data_addr_o[5:2]][8*k +: 8] <= data_wdata_o[8*k +: 8];
      end
      else if (data_req_o && !pending)
      begin
        pending  <= 1'b1;
        wait_cnt <= 2'(lcg_next() >> 16);   // 0 to 3 extra cycles
      end
      else if (data_req_o && wait_cnt == 0)
      begin
        pending    <= 1'b0;
        data_gnt_i <= 1'b1;
        data_err_i <= (data_addr_o >= FAULT_BASE);
      end
      else if (data_req_o)
        wait_cnt <= wait_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected values and checks
  ////////////////////////////////////////////////////////////////////////////

  // lane k is written when it lies inside the accessed bytes
  function automatic logic [3:0] exp_be(lsu_pkg::data_type_e size, logic [1:0] off);
    logic [3:0] be;
    int         bytes;
    if (size == lsu_pkg::SIZE_WORD)
      bytes = 4;
    else if (size == lsu_pkg::SIZE_HALF)
      bytes = 2;
    else
      bytes = 1;
    for (int k = 0; k < 4; k++)
      be[k] = (k >= int'(off)) && (k < int'(off) + bytes);
    return be;
  endfunction

  // lane k carries byte (k - off) of the ex data
  function automatic logic [31:0] rotate_lanes(logic [31:0] d, logic [1:0] off);
    logic [31:0] r;
    logic [1:0]  src;
    for (int k = 0; k < 4; k++)
    begin
      src = 2'(k) - off;
      r[8*k +: 8] = d[8*src +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] load_value(lsu_pkg::data_type_e size, logic sext,
                                             logic [31:0] addr);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = ref_mem[addr[5:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    if (size == lsu_pkg::SIZE_WORD) return w;
    if (size == lsu_pkg::SIZE_HALF) return {{16{sext & h[15]}}, h};
    return {{24{sext & b[7]}}, b};
  endfunction

  task automatic compare_value(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(bit cond, string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: %s", $time, what);
    end
  endtask

  // runs one access with handshake and lane checks and returns the load data
  task automatic run_access(logic we, lsu_pkg::data_type_e size, logic sext,
                            logic [31:0] addr, logic [31:0] wdata, output logic [31:0] rdata);
    logic fault;
    logic [3:0] be;
    logic [31:0] lanes;
    fault = (addr >= FAULT_BASE);
    be    = exp_be(size, addr[1:0]);
    lanes = rotate_lanes(wdata, addr[1:0]);
    @(posedge clk);
    data_req_ex_i      <= 1'b1;
    data_we_ex_i       <= we;
    data_type_ex_i     <= size;
    data_sign_ext_ex_i <= sext;
    data_addr_ex_i     <= addr;
    data_wdata_ex_i    <= wdata;
    ex_valid_i         <= 1'b1;
    @(negedge clk);
    while (!data_gnt_i)
    begin
      check_flag(data_req_o && data_addr_o == addr && !lsu_ready_ex_o,
                 "request not held stable before grant");
      @(negedge clk);
    end
    check_flag(data_req_o && lsu_ready_ex_o, "ready_ex not high in grant cycle");
    compare_value(data_we_o, we, "data_we_o");
    compare_value(load_err_o, fault && !we, "load_err_o");
    compare_value(store_err_o, fault && we, "store_err_o");
    if (we)
    begin
      compare_value(data_be_o, be, "data_be_o");
      compare_value(data_wdata_o, lanes, "data_wdata_o");
      if (!fault)
        for (int k = 0; k < 4; k++)
          if (be[k]) ref_mem[addr[5:2]][8*k +: 8] = lanes[8*k +: 8];
    end
    @(posedge clk);
    data_req_ex_i <= 1'b0;
    @(negedge clk);
    while (!data_rvalid_i)
      @(negedge clk);
    check_flag(!load_err_o && !store_err_o && lsu_ready_wb_o, "error or wb stall at rvalid");
    rdata = data_rdata_ex_o;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_test();
    @(negedge clk);
    check_flag(!data_req_o && !busy_o && !load_err_o && !store_err_o, "outputs after reset");
    check_flag(lsu_ready_ex_o && lsu_ready_wb_o, "ready low after reset");
  endtask

  task automatic store_test();
    logic [31:0] r;
    for (int o = 0; o < 4; o++)
      run_access(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 32'h08 + o, 32'h5a00_00c0 + o, r);
    run_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0c, 32'h1234_8765, r);
    run_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0e, 32'hffff_4321, r);
    run_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h10, 32'hdead_beef, r);
    for (int a = 8; a <= 16; a += 4)
    begin
      run_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, a, '0, r);
      compare_value(r, ref_mem[a >> 2], "merged word after stores");
    end
  endtask

  task automatic load_test();
    logic [31:0] r;
    for (int s = 0; s < 2; s++)
    begin
      for (int o = 0; o < 4; o++)
      begin
        run_access(1'b0, lsu_pkg::SIZE_BYTE, s[0], 32'h18 + o, '0, r);
        compare_value(r, load_value(lsu_pkg::SIZE_BYTE, s[0], 32'h18 + o), "byte load");
      end
      for (int o = 0; o < 4; o += 2)
      begin
        run_access(1'b0, lsu_pkg::SIZE_HALF, s[0], 32'h1c + o, '0, r);
        compare_value(r, load_value(lsu_pkg::SIZE_HALF, s[0], 32'h1c + o), "half load");
      end
    end
    run_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h20, '0, r);
    compare_value(r, ref_mem[8], "word load");
  endtask

  task automatic stall_test();
    logic [31:0] held;
    held = 'x;
    @(posedge clk);
    data_req_ex_i  <= 1'b1;
    data_we_ex_i   <= 1'b0;
    data_type_ex_i <= lsu_pkg::SIZE_WORD;
    data_addr_ex_i <= 32'h24;
    ex_valid_i     <= 1'b0;
    @(negedge clk);
    while (!data_gnt_i)
      @(negedge clk);
    // ex stalled with the request still up so the bus stays quiet
    repeat (4)
    begin
      @(negedge clk);
      check_flag(!data_req_o && busy_o, "new request or idle during ex stall");
      if (data_rvalid_i) held = data_rdata_ex_o;
    end
    @(posedge clk);
    ex_valid_i    <= 1'b1;
    data_req_ex_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_flag(!busy_o, "busy after stall released");
    compare_value(held, ref_mem[9], "load data during stall");
    repeat (3)
    begin
      @(negedge clk);
      compare_value(data_rdata_ex_o, ref_mem[9], "held load data");
    end
  endtask

  task automatic fault_test();
    logic [31:0] r;
    run_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h40, '0, r);
    run_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h44, 32'h0bad_f00d, r);
  endtask

  initial
  begin : watchdog
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run stopped after %0d cycles", cycle_cnt);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    rst_n              = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = lsu_pkg::SIZE_WORD;
    data_sign_ext_ex_i = 1'b0;
    data_addr_ex_i     = '0;
    data_wdata_ex_i    = '0;
    ex_valid_i         = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_test();
    store_test();
    load_test();
    stall_test();
    fault_test();
    repeat (2) @(posedge clk);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== lsu_top.f ====
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_top.sv
tb/lsu_assert.sv
tb/tb_lsu_top.sv

// ==== Makefile ====
SIM := obj_dir/sim_lsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_lsu_top \
		-f lsu_top.f --Mdir obj_dir -o sim_lsu

run: compile
	@out=$$(./$(SIM)); status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
